// File: logic/bbox_params.svh
/*
 * Bounding box stage parameters
 * Coordinate format, vertex count and pipeline depth shared by RTL and testbench
 */

`ifndef BBOX_PARAMS_SVH
`define BBOX_PARAMS_SVH

// Total bits in a signed fixed-point coordinate
`define BBOX_SIGFIG 24

// Fraction bits, integer part is [SIGFIG-1:RADIX]
`define BBOX_RADIX 10

// Vertices per triangle
`define BBOX_VERTS 3

// Register stages from input capture to outputs
`define BBOX_PIPE_DEPTH 3

`endif

// File: logic/bbox_pkg.sv
/*
 * Bounding box types
 * Signed fixed-point coordinate and the one-hot MSAA sample grid selector
 */

`include "bbox_params.svh"

package bbox_pkg;

    // Signed fixed point, BBOX_RADIX fraction bits
    typedef logic signed [`BBOX_SIGFIG-1:0] coord_t;

    // Sample grid selector, one-hot
    // Each step down doubles the samples along an axis
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000,  // Pixel grid, no fraction bits kept
        MSAA_4X  = 4'b0100,  // Half-pixel grid, 1 fraction bit
        MSAA_16X = 4'b0010,  // Quarter-pixel grid, 2 fraction bits
        MSAA_64X = 4'b0001   // Eighth-pixel grid, 3 fraction bits
    } msaa_mode_e;

endpackage

// File: logic/bbox_extent.sv
/*
 * Triangle extent
 * Picks the lowest and highest vertex on each axis with one-hot selects
 * and muxes them out as the raw lower-left and upper-right box corners
 */

`include "bbox_params.svh"

module bbox_extent
    import bbox_pkg::*;
(
    input  logic   clk,                      // Assertion sampling only
    input  coord_t i_vert_x [`BBOX_VERTS],
    input  coord_t i_vert_y [`BBOX_VERTS],
    output coord_t o_ll_x,
    output coord_t o_ll_y,
    output coord_t o_ur_x,
    output coord_t o_ur_y
);

    localparam int NV = `BBOX_VERTS;

    coord_t vert [2][NV];                    // [axis][vertex], axis 0 is x

    always_comb begin
        for (int v = 0; v < NV; v++) begin
            vert[0][v] = i_vert_x[v];
            vert[1][v] = i_vert_y[v];
        end
    end

    for (genvar a = 0; a < 2; a++) begin : g_axis
        logic [NV-1:0] sel_lo;               // One-hot, lowest vertex
        logic [NV-1:0] sel_hi;               // One-hot, highest vertex
        coord_t        lo;
        coord_t        hi;

        // Pairwise compares
        // Strict against earlier vertices, so a tie goes to the lower index
        always_comb begin
            for (int v = 0; v < NV; v++) begin
                sel_lo[v] = 1'b1;
                sel_hi[v] = 1'b1;
                for (int w = 0; w < NV; w++) begin
                    if (w < v) begin
                        sel_lo[v] &= (vert[a][v] < vert[a][w]);
                        sel_hi[v] &= (vert[a][v] > vert[a][w]);
                    end else if (w > v) begin
                        sel_lo[v] &= (vert[a][v] <= vert[a][w]);
                        sel_hi[v] &= (vert[a][v] >= vert[a][w]);
                    end
                end
            end
        end

        // AND-OR mux on the selects
        always_comb begin
            lo = '0;
            hi = '0;
            for (int v = 0; v < NV; v++) begin
                lo |= vert[a][v] & {`BBOX_SIGFIG{sel_lo[v]}};
                hi |= vert[a][v] & {`BBOX_SIGFIG{sel_hi[v]}};
            end
        end

        a_sel_lo_onehot: assert property (@(posedge clk) $onehot(sel_lo));
        a_sel_hi_onehot: assert property (@(posedge clk) $onehot(sel_hi));
        a_lo_le_hi:      assert property (@(posedge clk) lo <= hi);
    end

    assign o_ll_x = g_axis[0].lo;
    assign o_ll_y = g_axis[1].lo;
    assign o_ur_x = g_axis[0].hi;
    assign o_ur_y = g_axis[1].hi;

endmodule

// File: logic/bbox_grid_clip.sv
/*
 * Grid rounding and screen clipping
 * Floors box corners to the MSAA sample grid, clamps them to the screen
 * and rejects boxes that miss the screen entirely
 */

`include "bbox_params.svh"

module bbox_grid_clip
    import bbox_pkg::*;
(
    input  logic       clk,                  // Assertion sampling only
    input  coord_t     i_ll_x,
    input  coord_t     i_ll_y,
    input  coord_t     i_ur_x,
    input  coord_t     i_ur_y,
    input  coord_t     i_screen_w,
    input  coord_t     i_screen_h,
    input  msaa_mode_e i_msaa,
    input  logic       i_valid,
    output coord_t     o_ll_x,
    output coord_t     o_ll_y,
    output coord_t     o_ur_x,
    output coord_t     o_ur_y,
    output logic       o_accept
);

    logic [`BBOX_SIGFIG-1:0] mask;           // Clears bits below sample spacing
    logic [`BBOX_SIGFIG-1:0] spacing;        // One sample step
    coord_t                  corner  [4];    // ll_x, ll_y, ur_x, ur_y
    coord_t                  floored [4];

    always_comb begin
        case (i_msaa)
            MSAA_1X:  mask = {`BBOX_SIGFIG{1'b1}} << `BBOX_RADIX;
            MSAA_4X:  mask = {`BBOX_SIGFIG{1'b1}} << (`BBOX_RADIX - 1);
            MSAA_16X: mask = {`BBOX_SIGFIG{1'b1}} << (`BBOX_RADIX - 2);
            MSAA_64X: mask = {`BBOX_SIGFIG{1'b1}} << (`BBOX_RADIX - 3);
            default:  mask = {`BBOX_SIGFIG{1'b1}} << `BBOX_RADIX;  // Pixel grid
        endcase
    end

    assign spacing = ~mask + 1'b1;           // Lowest kept bit

    assign corner[0] = i_ll_x;
    assign corner[1] = i_ll_y;
    assign corner[2] = i_ur_x;
    assign corner[3] = i_ur_y;

    // Two's complement, so masking floors toward minus infinity
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            floored[c] = corner[c] & mask;
        end
    end

    // Clamp lower-left to origin, upper-right to screen limit
    assign o_ll_x = (floored[0] < 0) ? '0 : floored[0];
    assign o_ll_y = (floored[1] < 0) ? '0 : floored[1];
    assign o_ur_x = (floored[2] >= i_screen_w) ? i_screen_w : floored[2];
    assign o_ur_y = (floored[3] >= i_screen_h) ? i_screen_h : floored[3];

    // Reject if wholly right/above or wholly left/below
    assign o_accept = i_valid
                   && (o_ll_x < i_screen_w)
                   && (o_ll_y < i_screen_h)
                   && (floored[2] > 0)
                   && (floored[3] > 0);

    for (genvar c = 0; c < 4; c++) begin : g_floor_chk
        a_floor_step: assert property (@(posedge clk)
            (corner[c] - floored[c]) < spacing);
    end

    a_ur_on_screen: assert property (@(posedge clk)
        o_accept |-> (o_ur_x <= i_screen_w) && (o_ur_y <= i_screen_h));

endmodule

// File: logic/bbox_pipe.sv
/*
 * Stallable delay line
 * DEPTH registers shifting on every edge with i_halt low, cleared on reset
 */

`include "bbox_params.svh"

module bbox_pipe #(
    parameter int DEPTH = `BBOX_PIPE_DEPTH,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_halt,         // Freeze all stages
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data
);

    logic [WIDTH-1:0] stage [DEPTH];         // stage[0] is nearest the input

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int s = 0; s < DEPTH; s++) begin
                stage[s] <= '0;
            end
        end else if (!i_halt) begin
            stage[0] <= i_data;
            for (int s = 1; s < DEPTH; s++) begin
                stage[s] <= stage[s-1];
            end
        end
    end

    assign o_data = stage[DEPTH-1];

    // Halted edge must leave the output untouched
    a_hold_on_halt: assert property (@(posedge clk) disable iff (i_rst)
        (i_halt && !i_rst) |=> $stable(o_data));

endmodule

// File: logic/bbox.sv
/*
 * Bounding box stage, top level
 * Extent, grid rounding and clipping, then a fixed stallable delay
 * carrying box, vertices and valid to the outputs
 */

`include "bbox_params.svh"

module bbox
    import bbox_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst,
    input  coord_t     i_vert_x [`BBOX_VERTS],
    input  coord_t     i_vert_y [`BBOX_VERTS],
    input  logic       i_valid,
    input  coord_t     i_screen_w,
    input  coord_t     i_screen_h,
    input  msaa_mode_e i_msaa,
    input  logic       i_halt,
    output coord_t     o_vert_x [`BBOX_VERTS],
    output coord_t     o_vert_y [`BBOX_VERTS],
    output coord_t     o_ll_x,
    output coord_t     o_ll_y,
    output coord_t     o_ur_x,
    output coord_t     o_ur_y,
    output logic       o_valid
);

    localparam int NV       = `BBOX_VERTS;
    localparam int SF       = `BBOX_SIGFIG;
    localparam int VERT_LSB = 1 + 4 * SF;    // Above valid and four corners
    localparam int PIPE_W   = VERT_LSB + 2 * NV * SF;

    coord_t            raw_ll_x;
    coord_t            raw_ll_y;
    coord_t            raw_ur_x;
    coord_t            raw_ur_y;
    coord_t            clip_ll_x;
    coord_t            clip_ll_y;
    coord_t            clip_ur_x;
    coord_t            clip_ur_y;
    logic              accept;
    logic [PIPE_W-1:0] pipe_in;
    logic [PIPE_W-1:0] pipe_out;

    bbox_extent u_extent (
        .clk      (clk),
        .i_vert_x (i_vert_x),
        .i_vert_y (i_vert_y),
        .o_ll_x   (raw_ll_x),
        .o_ll_y   (raw_ll_y),
        .o_ur_x   (raw_ur_x),
        .o_ur_y   (raw_ur_y)
    );

    bbox_grid_clip u_grid_clip (
        .clk        (clk),
        .i_ll_x     (raw_ll_x),
        .i_ll_y     (raw_ll_y),
        .i_ur_x     (raw_ur_x),
        .i_ur_y     (raw_ur_y),
        .i_screen_w (i_screen_w),
        .i_screen_h (i_screen_h),
        .i_msaa     (i_msaa),
        .i_valid    (i_valid),
        .o_ll_x     (clip_ll_x),
        .o_ll_y     (clip_ll_y),
        .o_ur_x     (clip_ur_x),
        .o_ur_y     (clip_ur_y),
        .o_accept   (accept)
    );

    // Pack: valid at bit 0, then ll_x, ll_y, ur_x, ur_y, then x/y per vertex
    assign pipe_in[0]            = accept;
    assign pipe_in[1 +: SF]      = clip_ll_x;
    assign pipe_in[1 + SF +: SF] = clip_ll_y;
    assign pipe_in[1 + 2*SF +: SF] = clip_ur_x;
    assign pipe_in[1 + 3*SF +: SF] = clip_ur_y;

    for (genvar v = 0; v < NV; v++) begin : g_vert
        assign pipe_in[VERT_LSB + 2*v*SF +: SF]     = i_vert_x[v];
        assign pipe_in[VERT_LSB + (2*v+1)*SF +: SF] = i_vert_y[v];
        assign o_vert_x[v] = pipe_out[VERT_LSB + 2*v*SF +: SF];
        assign o_vert_y[v] = pipe_out[VERT_LSB + (2*v+1)*SF +: SF];
    end

    bbox_pipe #(
        .DEPTH (`BBOX_PIPE_DEPTH),
        .WIDTH (PIPE_W)
    ) u_pipe (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_halt (i_halt),
        .i_data (pipe_in),
        .o_data (pipe_out)
    );

    assign o_valid = pipe_out[0];
    assign o_ll_x  = pipe_out[1 +: SF];
    assign o_ll_y  = pipe_out[1 + SF +: SF];
    assign o_ur_x  = pipe_out[1 + 2*SF +: SF];
    assign o_ur_y  = pipe_out[1 + 3*SF +: SF];

    // Box ordering survives clipping and the delay line
    a_box_ordered: assert property (@(posedge clk) disable iff (i_rst)
        o_valid |-> (o_ll_x <= o_ur_x) && (o_ll_y <= o_ur_y));

endmodule

// File: verification/bbox_tb.sv
/*
 * Testbench for the bounding box stage
 * Random triangles from an LFSR, a reference model with a stall-aware
 * delay line, output checks after every edge and a watchdog
 */

`include "bbox_params.svh"

module bbox_tb
    import bbox_pkg::*;
();

    localparam int NV       = `BBOX_VERTS;
    localparam int DEPTH    = `BBOX_PIPE_DEPTH;
    localparam int ONE      = 1 << `BBOX_RADIX;   // One pixel
    localparam int PERIOD   = 8;
    localparam int N_EXTENT = 40;
    localparam int N_GRID   = 20;                 // Per MSAA mode
    localparam int N_CLIP   = 40;                 // Crossing, and as many wholly off
    localparam int N_STALL  = 100;
    localparam int N_TOTAL  = N_EXTENT + 4 * N_GRID + 2 * N_CLIP + N_STALL;

    // One output beat as the model expects it
    typedef struct packed {
        logic            valid;
        coord_t          ll_x;
        coord_t          ll_y;
        coord_t          ur_x;
        coord_t          ur_y;
        coord_t [NV-1:0] vx;
        coord_t [NV-1:0] vy;
    } entry_t;

    logic       clk = 1'b0;
    logic       i_rst;
    coord_t     i_vert_x [NV];
    coord_t     i_vert_y [NV];
    logic       i_valid;
    coord_t     i_screen_w;
    coord_t     i_screen_h;
    msaa_mode_e i_msaa;
    logic       i_halt;
    coord_t     o_vert_x [NV];
    coord_t     o_vert_y [NV];
    coord_t     o_ll_x;
    coord_t     o_ll_y;
    coord_t     o_ur_x;
    coord_t     o_ur_y;
    logic       o_valid;

    logic [31:0] lfsr = 32'h9734_ced2;
    entry_t      model [DEPTH];                   // model[0] newest
    entry_t      prev_out;                        // Outputs after the last edge
    int          checks;
    int          errors;
    int          checks_mark;
    int          errors_mark;
    int          sent_count;                      // Accepted triangles in
    int          out_count;                       // Valid beats out

    always #(PERIOD / 2) clk = ~clk;

    bbox i_bbox (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_vert_x   (i_vert_x),
        .i_vert_y   (i_vert_y),
        .i_valid    (i_valid),
        .i_screen_w (i_screen_w),
        .i_screen_h (i_screen_h),
        .i_msaa     (i_msaa),
        .i_halt     (i_halt),
        .o_vert_x   (o_vert_x),
        .o_vert_y   (o_vert_y),
        .o_ll_x     (o_ll_x),
        .o_ll_y     (o_ll_y),
        .o_ur_x     (o_ur_x),
        .o_ur_y     (o_ur_y),
        .o_valid    (o_valid)
    );

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int next_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);               // One step per bit
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic msaa_mode_e pick_mode(input int k);
        case (k)
            0:       return MSAA_1X;
            1:       return MSAA_4X;
            2:       return MSAA_16X;
            default: return MSAA_64X;
        endcase
    endfunction

    function automatic int kept_bits(input msaa_mode_e m);
        case (m)
            MSAA_4X:  return 1;
            MSAA_16X: return 2;
            MSAA_64X: return 3;
            default:  return 0;                   // Whole pixels
        endcase
    endfunction

    // Floor toward minus infinity by subtracting a non-negative remainder
    function automatic coord_t floor_to_grid(input coord_t v, input int keep);
        int val;
        int step;
        int r;
        val  = v;
        step = 1 << (`BBOX_RADIX - keep);
        r    = val % step;
        if (r < 0) r += step;                     // % keeps the dividend's sign
        return coord_t'(val - r);
    endfunction

    // Expected beat for the inputs currently driven
    function automatic entry_t predict_box();
        entry_t e;
        coord_t lo_x;
        coord_t hi_x;
        coord_t lo_y;
        coord_t hi_y;
        int     keep;
        lo_x = i_vert_x[0];
        hi_x = i_vert_x[0];
        lo_y = i_vert_y[0];
        hi_y = i_vert_y[0];
        for (int v = 1; v < NV; v++) begin
            if (i_vert_x[v] < lo_x) lo_x = i_vert_x[v];
            if (i_vert_x[v] > hi_x) hi_x = i_vert_x[v];
            if (i_vert_y[v] < lo_y) lo_y = i_vert_y[v];
            if (i_vert_y[v] > hi_y) hi_y = i_vert_y[v];
        end
        keep = kept_bits(i_msaa);
        lo_x = floor_to_grid(lo_x, keep);
        lo_y = floor_to_grid(lo_y, keep);
        hi_x = floor_to_grid(hi_x, keep);
        hi_y = floor_to_grid(hi_y, keep);
        e.ll_x  = (lo_x < 0) ? coord_t'(0) : lo_x;
        e.ll_y  = (lo_y < 0) ? coord_t'(0) : lo_y;
        e.ur_x  = (hi_x >= i_screen_w) ? i_screen_w : hi_x;
        e.ur_y  = (hi_y >= i_screen_h) ? i_screen_h : hi_y;
        e.valid = i_valid && (e.ll_x < i_screen_w) && (e.ll_y < i_screen_h)
               && (hi_x > 0) && (hi_y > 0);      // Off-screen boxes dropped
        for (int v = 0; v < NV; v++) begin
            e.vx[v] = i_vert_x[v];
            e.vy[v] = i_vert_y[v];
        end
        return e;
    endfunction

    function automatic entry_t sample_outputs();
        entry_t e;
        e.valid = o_valid;
        e.ll_x  = o_ll_x;
        e.ll_y  = o_ll_y;
        e.ur_x  = o_ur_x;
        e.ur_y  = o_ur_y;
        for (int v = 0; v < NV; v++) begin
            e.vx[v] = o_vert_x[v];
            e.vy[v] = o_vert_y[v];
        end
        return e;
    endfunction

    task automatic check_value(input string name, input longint got, input longint exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic match_entry(input entry_t got, input entry_t exp);
        check_value("o_valid", got.valid, exp.valid);
        check_value("o_ll_x", got.ll_x, exp.ll_x);
        check_value("o_ll_y", got.ll_y, exp.ll_y);
        check_value("o_ur_x", got.ur_x, exp.ur_x);
        check_value("o_ur_y", got.ur_y, exp.ur_y);
        for (int v = 0; v < NV; v++) begin
            check_value($sformatf("o_vert_x[%0d]", v), got.vx[v], exp.vx[v]);
            check_value($sformatf("o_vert_y[%0d]", v), got.vy[v], exp.vy[v]);
        end
    endtask

    // One clock edge: advance the model unless halted, then check outputs
    task automatic step_edge();
        logic   halted;
        entry_t now;
        @(posedge clk);
        halted = i_halt;                          // Inputs settled since last +1
        if (!halted) begin
            for (int s = DEPTH - 1; s > 0; s--) begin
                model[s] = model[s-1];
            end
            model[0] = predict_box();
        end
        #1;
        now = sample_outputs();
        if (halted) begin
            checks++;
            assert (now == prev_out) else begin
                $display("FAIL t=%0t outputs expected %h got %h", $time, prev_out, now);
                errors++;
            end
        end else if (now.valid) begin
            out_count++;
        end
        match_entry(now, model[DEPTH-1]);
        prev_out = now;
    endtask

    // Hold the triangle until an edge with halt low takes it
    task automatic push_tri(input bit stall);
        do begin
            i_halt = stall && (next_bits(2) == 0);   // About one edge in four
            step_edge();
        end while (i_halt);
        if (model[0].valid) sent_count++;
    endtask

    task automatic drain_pipe();
        i_valid = 1'b0;
        i_halt  = 1'b0;
        repeat (DEPTH) step_edge();
    endtask

    task automatic gen_tri(input int lo_x, input int nb_x, input int lo_y, input int nb_y);
        for (int v = 0; v < NV; v++) begin
            i_vert_x[v] = coord_t'(lo_x + next_bits(nb_x));
            i_vert_y[v] = coord_t'(lo_y + next_bits(nb_y));
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-7s done: %0d checks, %0d errors", name,
                 checks - checks_mark, errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    initial begin
        i_rst      = 1'b1;
        i_valid    = 1'b0;
        i_halt     = 1'b0;
        i_screen_w = '0;
        i_screen_h = '0;
        i_msaa     = MSAA_1X;
        for (int v = 0; v < NV; v++) begin
            i_vert_x[v] = '0;
            i_vert_y[v] = '0;
        end
        for (int s = 0; s < DEPTH; s++) begin
            model[s] = '0;
        end
        checks = 0;
        errors = 0;
        checks_mark = 0;
        errors_mark = 0;
        repeat (3) @(posedge clk);
        #1;
        i_rst = 1'b0;

        // Cleared pipeline, nothing sent yet
        prev_out = sample_outputs();
        match_entry(prev_out, '0);
        end_test("reset");

        // Large screen, pixel grid, some invalid slots
        i_screen_w = coord_t'(4096 * ONE);
        i_screen_h = coord_t'(4096 * ONE);
        repeat (N_EXTENT) begin
            gen_tri(0, 22, 0, 22);
            i_valid = (next_bits(2) != 0);
            push_tri(1'b0);
        end
        drain_pipe();
        end_test("extent");

        for (int m = 0; m < 4; m++) begin
            i_msaa = pick_mode(m);
            repeat (N_GRID) begin
                gen_tri(0, 22, 0, 22);
                i_valid = 1'b1;
                push_tri(1'b0);
            end
        end
        drain_pipe();
        end_test("grid");

        // 320x240 screen, boxes crossing every edge
        i_screen_w = coord_t'(320 * ONE);
        i_screen_h = coord_t'(240 * ONE);
        i_valid    = 1'b1;
        repeat (N_CLIP) begin
            i_msaa = pick_mode(next_bits(2));
            gen_tri(-256 * ONE, 20, -256 * ONE, 20);
            push_tri(1'b0);
        end
        for (int k = 0; k < N_CLIP; k++) begin
            i_msaa = pick_mode(next_bits(2));
            case (k % 4)
                0:       gen_tri(-(1 << 18), 18, 0, 18);              // Left
                1:       gen_tri(320 * ONE, 18, 0, 18);               // Right
                2:       gen_tri(0, 18, -(1 << 18), 18);              // Below
                default: gen_tri(0, 18, 240 * ONE, 18);               // Above
            endcase
            push_tri(1'b0);
        end
        drain_pipe();
        end_test("clip");

        // Random halts, every accepted triangle must come out once
        sent_count = 0;
        out_count  = 0;
        repeat (N_STALL) begin
            i_msaa  = pick_mode(next_bits(2));
            gen_tri(-256 * ONE, 20, -256 * ONE, 20);
            i_valid = (next_bits(3) != 0);
            push_tri(1'b1);
        end
        drain_pipe();
        check_value("o_valid beats", out_count, sent_count);
        end_test("stall");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Budget of four clocks per triangle plus slack for reset and drains
    initial begin
        #((N_TOTAL * 4 + 50) * PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: project.f
+incdir+logic
logic/bbox_pkg.sv
logic/bbox_extent.sv
logic/bbox_grid_clip.sv
logic/bbox_pipe.sv
logic/bbox.sv
verification/bbox_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the bounding box testbench with Verilator.
# Exit status is 0 only when the log holds no failure and reports a pass.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=bbox_sim
LOG=sim.log

echo "Compiling with Verilator"
verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module bbox_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

echo "Running simulation"
"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
